//--- include/icache_defs.svh
// Instruction cache geometry and memory beat protocol definitions
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Direct-mapped array, 16 lines of 64 bytes
`define ICACHE_LINES 16
`define ICACHE_INDEX_W 4
`define ICACHE_TAG_W 22

// Refill transfers, in 64-bit beats
`define ICACHE_BEAT_W 64
`define ICACHE_LINE_BEATS 8
`define ICACHE_BEAT_IDX_W 3

// Whole line as written into the array
`define ICACHE_LINE_W (`ICACHE_LINE_BEATS * `ICACHE_BEAT_W)

// Hit counter visible at the top level
`define ICACHE_HITCNT_W 16

`endif

//--- verilog/icache_pkg.sv
// Shared request, response and control types of the instruction cache
`include "icache_defs.svh"

package icache_pkg;

	// Fetch address from the fetch unit
	typedef logic [31:0] fetch_req_t;

	// One response to the fetch unit
	typedef struct packed {
		logic [31:0] inst0;
		logic [31:0] inst1;
		logic inst1_valid;
		logic pagefault;
	} fetch_rsp_t;

	// Beat address, 8-byte aligned
	typedef logic [31:0] mem_req_t;

	// One refill beat from memory
	typedef struct packed {
		logic [`ICACHE_BEAT_W-1:0] data;
		logic pagefault;
	} mem_rsp_t;

	// Controller FSM
	typedef enum logic [2:0] {
		IDLE = 3'd0,
		LOOKUP = 3'd1,
		MEMREQ = 3'd2,
		RESPOND = 3'd3,
		FLUSH = 3'd4
	} ctrl_state_e;

	// Where the aligner takes its word from
	typedef enum logic {
		CACHE = 1'b0,
		FILL = 1'b1
	} word_src_e;

endpackage

//--- verilog/icache_miss_ctrl.sv
// Instruction cache controller sequencing lookup, refill, response and flush
`include "icache_defs.svh"

module icache_miss_ctrl (
	input	logic iCLOCK,
	input	logic inRESET,
	input	logic flush,
	input	logic req_valid,
	output	logic req_ready,
	input	icache_pkg::fetch_req_t req,
	output	icache_pkg::fetch_req_t fetch_addr,
	input	logic lookup_hit,
	output	logic rd_en,
	output	logic wr_en,
	output	icache_pkg::word_src_e src,
	output	logic load,
	output	logic rsp_valid,
	input	logic rsp_ready,
	output	logic mem_req_valid,
	input	logic mem_req_ready,
	output	icache_pkg::mem_req_t mem_req,
	input	logic fill_last,
	input	logic fill_fault,
	output	logic [`ICACHE_HITCNT_W-1:0] hit_count
);

	icache_pkg::ctrl_state_e state;
	logic lookup_vld;
	logic issue_busy;
	logic [`ICACHE_BEAT_IDX_W-1:0] req_cnt;
	logic accept;
	logic hit;
	logic miss;
	logic fill_done;

	// Beat requests still outstanding block the next fetch
	assign req_ready = (state == icache_pkg::IDLE) && !flush && !issue_busy;
	assign accept = req_valid && req_ready;

	// Second LOOKUP cycle sees the registered array result
	assign rd_en = (state == icache_pkg::LOOKUP) && !lookup_vld;
	assign hit = (state == icache_pkg::LOOKUP) && lookup_vld && lookup_hit;
	assign miss = (state == icache_pkg::LOOKUP) && lookup_vld && !lookup_hit;

	assign fill_done = (state == icache_pkg::MEMREQ) && (fill_last || fill_fault);
	// A faulting line is never written
	assign wr_en = fill_done && !fill_fault;
	assign load = hit || fill_done;
	assign src = (state == icache_pkg::MEMREQ) ? icache_pkg::FILL : icache_pkg::CACHE;
	assign rsp_valid = (state == icache_pkg::RESPOND);

	assign mem_req_valid = issue_busy;
	assign mem_req = {fetch_addr[31:6], req_cnt, 3'b000};

	// Fetch address, held for the whole transaction
	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			fetch_addr <= req;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= icache_pkg::IDLE;
			lookup_vld <= 1'b0;
		end
		else begin
			case (state)
				icache_pkg::IDLE: begin
					if (flush) begin
						state <= icache_pkg::FLUSH;
					end
					else if (accept) begin
						state <= icache_pkg::LOOKUP;
					end
				end
				icache_pkg::LOOKUP: begin
					if (!lookup_vld) begin
						lookup_vld <= 1'b1;
					end
					else begin
						lookup_vld <= 1'b0;
						state <= lookup_hit ? icache_pkg::RESPOND : icache_pkg::MEMREQ;
					end
				end
				icache_pkg::MEMREQ: begin
					if (fill_last || fill_fault) begin
						state <= icache_pkg::RESPOND;
					end
				end
				icache_pkg::RESPOND: begin
					if (rsp_ready) begin
						state <= icache_pkg::IDLE;
					end
				end
				icache_pkg::FLUSH: begin
					// Array clears its valid bits this cycle
					state <= icache_pkg::IDLE;
				end
				default: begin
					state <= icache_pkg::IDLE;
				end
			endcase
		end
	end

	// Beat request issue, runs on after a fault until all eight are sent
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			issue_busy <= 1'b0;
			req_cnt <= '0;
		end
		else if (miss) begin
			issue_busy <= 1'b1;
			req_cnt <= '0;
		end
		else if (issue_busy && mem_req_ready) begin
			req_cnt <= req_cnt + 1'b1;
			if (req_cnt == `ICACHE_BEAT_IDX_W'(`ICACHE_LINE_BEATS - 1)) begin
				issue_busy <= 1'b0;
			end
		end
	end

	// Hit counter
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			hit_count <= '0;
		end
		else if (hit) begin
			hit_count <= hit_count + 1'b1;
		end
	end

endmodule

//--- verilog/icache_tag_array.sv
// Direct-mapped tag, valid and line storage with a registered lookup
`include "icache_defs.svh"

module icache_tag_array (
	input	logic iCLOCK,
	input	logic inRESET,
	input	logic flush,
	input	logic rd_en,
	input	icache_pkg::fetch_req_t rd_addr,
	output	logic rd_hit,
	output	logic [`ICACHE_BEAT_W-1:0] rd_word,
	input	logic wr_en,
	input	logic [`ICACHE_LINE_W-1:0] wr_line
);

	logic [`ICACHE_LINES-1:0] valid;
	logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_LINES];
	logic [`ICACHE_LINE_W-1:0] data_mem [`ICACHE_LINES];
	icache_pkg::fetch_req_t addr_q;
	logic [`ICACHE_INDEX_W-1:0] rd_idx;
	logic [`ICACHE_INDEX_W-1:0] wr_idx;
	logic [`ICACHE_TAG_W-1:0] rd_tag;
	logic [`ICACHE_BEAT_IDX_W-1:0] rd_sel;

	// Tag 31:10, index 9:6, word 5:3
	assign rd_tag = rd_addr[31 -: `ICACHE_TAG_W];
	assign rd_idx = rd_addr[6 +: `ICACHE_INDEX_W];
	assign rd_sel = rd_addr[3 +: `ICACHE_BEAT_IDX_W];

	// Refill goes to the line of the last lookup
	assign wr_idx = addr_q[6 +: `ICACHE_INDEX_W];

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid <= '0;
		end
		else if (flush) begin
			valid <= '0;
		end
		else if (wr_en) begin
			valid[wr_idx] <= 1'b1;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rd_hit <= 1'b0;
		end
		else if (rd_en) begin
			rd_hit <= valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
		end
	end

	// Lookup data and captured address
	always_ff @(posedge iCLOCK) begin
		if (rd_en) begin
			addr_q <= rd_addr;
			rd_word <= data_mem[rd_idx][rd_sel * `ICACHE_BEAT_W +: `ICACHE_BEAT_W];
		end
	end

	// Full line write
	always_ff @(posedge iCLOCK) begin
		if (wr_en) begin
			tag_mem[wr_idx] <= addr_q[31 -: `ICACHE_TAG_W];
			data_mem[wr_idx] <= wr_line;
		end
	end

endmodule

//--- verilog/icache_line_fill.sv
// Refill beat collector building the line and capturing the critical word
`include "icache_defs.svh"

module icache_line_fill (
	input	logic iCLOCK,
	input	logic inRESET,
	input	logic start,
	input	icache_pkg::fetch_req_t addr,
	input	logic mem_rsp_valid,
	input	icache_pkg::mem_rsp_t mem_rsp,
	output	logic [`ICACHE_LINE_W-1:0] line,
	output	logic [`ICACHE_BEAT_W-1:0] crit_word,
	output	logic fill_last,
	output	logic fill_fault
);

	logic [`ICACHE_BEAT_IDX_W-1:0] beat_cnt;
	logic [`ICACHE_BEAT_IDX_W-1:0] crit_idx;
	logic discard;
	logic beat_last;

	// Every line gets eight beats, so the counter wraps onto the next line
	assign beat_last = (beat_cnt == `ICACHE_BEAT_IDX_W'(`ICACHE_LINE_BEATS - 1));

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			beat_cnt <= '0;
			discard <= 1'b0;
			fill_last <= 1'b0;
			fill_fault <= 1'b0;
		end
		else begin
			fill_last <= mem_rsp_valid && beat_last && !discard;
			fill_fault <= mem_rsp_valid && mem_rsp.pagefault && !discard;
			if (mem_rsp_valid) begin
				beat_cnt <= beat_cnt + 1'b1;
				// Drop the rest of a faulted line
				if (beat_last) begin
					discard <= 1'b0;
				end
				else if (mem_rsp.pagefault) begin
					discard <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (start) begin
			crit_idx <= addr[3 +: `ICACHE_BEAT_IDX_W];
		end
		if (mem_rsp_valid) begin
			// Beat k ends up in bits 64k and up
			line <= {mem_rsp.data, line[`ICACHE_LINE_W-1:`ICACHE_BEAT_W]};
			if (!discard && (beat_cnt == crit_idx)) begin
				crit_word <= mem_rsp.data;
			end
		end
	end

endmodule

//--- verilog/icache_fetch_align.sv
// Response register selecting the word source and aligning two instructions
`include "icache_defs.svh"

module icache_fetch_align (
	input	logic iCLOCK,
	input	logic inRESET,
	input	logic load,
	input	logic rsp_ready,
	input	icache_pkg::word_src_e src,
	input	logic [`ICACHE_BEAT_W-1:0] cache_word,
	input	logic [`ICACHE_BEAT_W-1:0] fill_word,
	input	logic fault,
	input	logic addr_hi,
	output	icache_pkg::fetch_rsp_t rsp
);

	logic [`ICACHE_BEAT_W-1:0] word;

	assign word = (src == icache_pkg::FILL) ? fill_word : cache_word;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rsp <= '0;
		end
		else if (load) begin
			rsp.pagefault <= fault;
			if (!addr_hi) begin
				rsp.inst0 <= word[31:0];
				rsp.inst1 <= word[63:32];
				rsp.inst1_valid <= 1'b1;
			end
			else begin
				// Upper half only, nothing follows in this word
				rsp.inst0 <= word[63:32];
				rsp.inst1 <= '0;
				rsp.inst1_valid <= 1'b0;
			end
		end
		else if (rsp_ready) begin
			rsp.inst1_valid <= 1'b0;
			rsp.pagefault <= 1'b0;
		end
	end

endmodule

//--- verilog/l1_instruction_cache.sv
// L1 instruction cache top connecting controller, array, refill and aligner
`include "icache_defs.svh"

module l1_instruction_cache (
	input	logic iCLOCK,
	input	logic inRESET,
	input	logic flush,
	// Fetch side
	input	logic req_valid,
	output	logic req_ready,
	input	icache_pkg::fetch_req_t req,
	output	logic rsp_valid,
	input	logic rsp_ready,
	output	icache_pkg::fetch_rsp_t rsp,
	// Memory side
	output	logic mem_req_valid,
	input	logic mem_req_ready,
	output	icache_pkg::mem_req_t mem_req,
	input	logic mem_rsp_valid,
	input	icache_pkg::mem_rsp_t mem_rsp,
	output	logic [`ICACHE_HITCNT_W-1:0] hit_count
);

	icache_pkg::fetch_req_t fetch_addr;
	icache_pkg::word_src_e src;
	logic lookup_hit;
	logic rd_en;
	logic wr_en;
	logic load;
	logic fill_last;
	logic fill_fault;
	logic [`ICACHE_BEAT_W-1:0] rd_word;
	logic [`ICACHE_BEAT_W-1:0] crit_word;
	logic [`ICACHE_LINE_W-1:0] line;

	icache_miss_ctrl ctrl0 (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req(req),
		.fetch_addr(fetch_addr),
		.lookup_hit(lookup_hit),
		.rd_en(rd_en),
		.wr_en(wr_en),
		.src(src),
		.load(load),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_req(mem_req),
		.fill_last(fill_last),
		.fill_fault(fill_fault),
		.hit_count(hit_count)
	);

	icache_tag_array tags0 (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.rd_en(rd_en),
		.rd_addr(fetch_addr),
		.rd_hit(lookup_hit),
		.rd_word(rd_word),
		.wr_en(wr_en),
		.wr_line(line)
	);

	// Critical word index is taken at lookup time
	icache_line_fill fill0 (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.start(rd_en),
		.addr(fetch_addr),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp(mem_rsp),
		.line(line),
		.crit_word(crit_word),
		.fill_last(fill_last),
		.fill_fault(fill_fault)
	);

	icache_fetch_align align0 (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.load(load),
		.rsp_ready(rsp_ready),
		.src(src),
		.cache_word(rd_word),
		.fill_word(crit_word),
		.fault(fill_fault),
		.addr_hi(fetch_addr[2]),
		.rsp(rsp)
	);

endmodule

//--- sim/icache_clkgen.sv
// Testbench clock and reset source, 10 ns clock with reset low for 5 cycles
module icache_clkgen (
	output	logic iCLOCK,
	output	logic inRESET
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		iCLOCK = 1'b0;
		forever #5 iCLOCK = ~iCLOCK;
	end

	initial begin
		inRESET = 1'b0;
		repeat (5) @(posedge iCLOCK);
		inRESET <= 1'b1;
	end

endmodule

//--- sim/icache_sva.sv
// Protocol assertions for the instruction cache controller
module icache_sva (
	input	logic iCLOCK,
	input	logic inRESET,
	input	logic req_valid,
	input	logic req_ready,
	input	logic rsp_valid,
	input	logic rsp_ready,
	input	logic mem_req_valid,
	input	logic mem_req_ready,
	input	logic [31:0] mem_req
);

	timeunit 1ns;
	timeprecision 1ps;

	logic pending;

	// One fetch in flight between acceptance and response
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pending <= 1'b0;
		end
		else if (req_valid && req_ready) begin
			pending <= 1'b1;
		end
		else if (rsp_valid && rsp_ready) begin
			pending <= 1'b0;
		end
	end

	mem_req_stable: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
		else $error("memory request changed while stalled");

	rsp_needs_req: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$rose(rsp_valid) |-> pending)
		else $error("response raised without an accepted request");

endmodule

//--- sim/icache_tb.sv
// Instruction cache testbench with memory responder, reference model and checks
`include "icache_defs.svh"

module icache_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TOTAL_REQ = 141;
	localparam int TIMEOUT = TOTAL_REQ * 60;
	localparam logic [31:0] INST_KEY = 32'h5A5A5A5A;

	logic iCLOCK;
	logic inRESET;
	logic flush;
	logic req_valid;
	logic req_ready;
	icache_pkg::fetch_req_t req;
	logic rsp_valid;
	logic rsp_ready;
	icache_pkg::fetch_rsp_t rsp;
	logic mem_req_valid;
	logic mem_req_ready;
	icache_pkg::mem_req_t mem_req;
	logic mem_rsp_valid;
	icache_pkg::mem_rsp_t mem_rsp;
	logic [`ICACHE_HITCNT_W-1:0] hit_count;

	// Reference state of the array
	bit m_valid [`ICACHE_LINES];
	logic [`ICACHE_TAG_W-1:0] m_tag [`ICACHE_LINES];
	int m_hits = 0;

	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int n_req = 0;
	int n_rsp = 0;
	int cycles = 0;
	int ready_pct = 80;
	int rsp_wait = 0;
	logic [31:0] beat_q [$];

	icache_clkgen clk0 (.iCLOCK(iCLOCK), .inRESET(inRESET));

	l1_instruction_cache dut0 (.*);

	bind icache_miss_ctrl icache_sva sva0 (.*);

	// Random back-pressure on the fetch response
	always @(posedge iCLOCK) begin
		rsp_ready <= ($urandom_range(0, 99) < ready_pct);
	end

	// Memory responder, beats come back in order after a short random wait
	always @(posedge iCLOCK) begin
		mem_req_ready <= ($urandom_range(0, 3) != 0);
		mem_rsp_valid <= 1'b0;
		if (beat_q.size() > 0) begin
			if (rsp_wait == 0) begin
				mem_rsp_valid <= 1'b1;
				mem_rsp.data <= {(beat_q[0] + 32'd4) ^ INST_KEY, beat_q[0] ^ INST_KEY};
				mem_rsp.pagefault <= (beat_q[0][31:12] == 20'h0000F);
				void'(beat_q.pop_front());
				rsp_wait = $urandom_range(0, 3);
			end
			else begin
				rsp_wait = rsp_wait - 1;
			end
		end
	end

	always @(negedge iCLOCK) begin
		if (mem_req_valid && mem_req_ready) begin
			beat_q.push_back(mem_req);
		end
		if (rsp_valid && rsp_ready) begin
			n_rsp++;
		end
	end

	always @(posedge iCLOCK) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("Run stopped after %0d cycles without finishing the tests", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic check_val(input string test, input string what,
			input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("FAIL %s %s: expected %h actual %h", test, what, exp, act);
			errors++;
		end
	endtask

	// One fetch through the handshakes, checked against the model
	task automatic fetch_check(input string test, input logic [31:0] addr);
		logic [31:0] base;
		logic [31:0] lo;
		logic [31:0] hi;
		icache_pkg::fetch_rsp_t held;
		bit stalled;
		bit fault;
		int idx;
		base = {addr[31:3], 3'b000};
		lo = base ^ INST_KEY;
		hi = (base + 32'd4) ^ INST_KEY;
		fault = (addr[31:12] == 20'h0000F);
		idx = addr[9:6];
		if (m_valid[idx] && m_tag[idx] == addr[31:10]) begin
			m_hits++;
		end
		else if (!fault) begin
			m_valid[idx] = 1'b1;
			m_tag[idx] = addr[31:10];
		end
		@(posedge iCLOCK);
		req_valid <= 1'b1;
		req <= addr;
		do begin
			@(negedge iCLOCK);
		end while (!req_ready);
		@(posedge iCLOCK);
		req_valid <= 1'b0;
		n_req++;
		stalled = 1'b0;
		while (1) begin
			@(negedge iCLOCK);
			if (rsp_valid) begin
				if (req_ready) begin
					$display("ERROR %s: req_ready high while a response waits", test);
					errors++;
				end
				if (stalled && rsp !== held) begin
					$display("ERROR %s: response changed while rsp_ready was low", test);
					errors++;
				end
				if (rsp_ready) begin
					break;
				end
				stalled = 1'b1;
				held = rsp;
			end
		end
		check_val(test, "pagefault", 64'(fault), 64'(rsp.pagefault));
		if (!fault) begin
			check_val(test, "inst1_valid", 64'(!addr[2]), 64'(rsp.inst1_valid));
			check_val(test, "inst0", 64'(addr[2] ? hi : lo), 64'(rsp.inst0));
			if (!addr[2]) begin
				check_val(test, "inst1", 64'(hi), 64'(rsp.inst1));
			end
		end
		check_val(test, "hit_count", 64'(m_hits[`ICACHE_HITCNT_W-1:0]), 64'(hit_count));
		@(posedge iCLOCK);
	endtask

	task automatic flush_cache();
		@(posedge iCLOCK);
		flush <= 1'b1;
		@(posedge iCLOCK);
		flush <= 1'b0;
		for (int i = 0; i < `ICACHE_LINES; i++) begin
			m_valid[i] = 1'b0;
		end
	endtask

	task automatic report_test(input string test, input int err_before);
		if (errors == err_before) begin
			$display("test %-12s passed", test);
			tests_passed++;
		end
		else begin
			$display("test %-12s failed with %0d errors", test, errors - err_before);
			tests_failed++;
		end
	endtask

	function automatic logic [31:0] random_addr();
		// Mostly the 4 KB window, sometimes the fault page
		if ($urandom_range(0, 7) == 0) begin
			return 32'h0000F000 | ($urandom & 32'h00000FFC);
		end
		return 32'h00001000 | ($urandom & 32'h00000FFC);
	endfunction

	initial begin
		int err0;
		logic [`ICACHE_HITCNT_W-1:0] hc0;
		void'($urandom(34));
		flush = 1'b0;
		req_valid = 1'b0;
		req = '0;
		rsp_ready = 1'b0;
		mem_req_ready = 1'b0;
		mem_rsp_valid = 1'b0;
		mem_rsp = '0;
		for (int i = 0; i < `ICACHE_LINES; i++) begin
			m_valid[i] = 1'b0;
			m_tag[i] = '0;
		end
		wait (inRESET);
		@(posedge iCLOCK);

		err0 = errors;
		for (int r = 0; r < 2; r++) begin
			for (int i = 0; i < 8; i++) begin
				fetch_check("miss_hit", 32'h00001008 + 32'(i * 64));
			end
		end
		for (int i = 0; i < 30; i++) begin
			fetch_check("miss_hit", 32'h00001000 | ($urandom & 32'h00000FFC));
		end
		report_test("miss_hit", err0);

		err0 = errors;
		for (int i = 0; i < 16; i++) begin
			fetch_check("alignment", 32'h00001800 + 32'(i * 4));
		end
		report_test("alignment", err0);

		err0 = errors;
		fetch_check("page_fault", 32'h0000F040);
		hc0 = hit_count;
		fetch_check("page_fault", 32'h0000F040);
		fetch_check("page_fault", 32'h0000F044);
		if (hit_count != hc0) begin
			$display("ERROR page_fault: a faulting line was counted as a hit");
			errors++;
		end
		report_test("page_fault", err0);

		err0 = errors;
		for (int i = 0; i < 8; i++) begin
			fetch_check("flush", 32'h00001200 + 32'(i * 64));
		end
		flush_cache();
		hc0 = hit_count;
		for (int i = 0; i < 8; i++) begin
			fetch_check("flush", 32'h00001200 + 32'(i * 64));
		end
		if (hit_count != hc0) begin
			$display("ERROR flush: lines still hit after the flush");
			errors++;
		end
		report_test("flush", err0);

		err0 = errors;
		ready_pct = 30;
		for (int i = 0; i < 60; i++) begin
			fetch_check("backpressure", random_addr());
		end
		ready_pct = 80;
		repeat (4) @(posedge iCLOCK);
		if (n_rsp != n_req) begin
			$display("ERROR backpressure: %0d responses for %0d requests", n_rsp, n_req);
			errors++;
		end
		report_test("backpressure", err0);

		$display("tests passed %0d, failed %0d, errors %0d, requests %0d",
			tests_passed, tests_failed, errors, n_req);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end
		else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- l1_instruction_cache.f
+incdir+include
verilog/icache_pkg.sv
verilog/icache_miss_ctrl.sv
verilog/icache_tag_array.sv
verilog/icache_line_fill.sv
verilog/icache_fetch_align.sv
verilog/l1_instruction_cache.sv
sim/icache_clkgen.sv
sim/icache_sva.sv
sim/icache_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = icache_tb
FILELIST  = l1_instruction_cache.f
BUILD     = obj_dir
BIN       = $(BUILD)/V$(TOP)
LOG       = sim.log

SRCS = $(shell grep -v '^+' $(FILELIST)) include/icache_defs.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
